// ==== hdl/aw_channel.sv ====
`timescale 1ns/1ps

module aw_channel (
	input  axi_pkg::wstate_t              cs,
	input  axi_pkg::slave_sel_t           slave,
	input  logic [axi_pkg::id_bits-1:0]   awid_m0,
	input  logic [axi_pkg::id_bits-1:0]   awid_m1,
	input  logic [axi_pkg::addr_bits-1:0] awaddr_m0,
	input  logic [axi_pkg::addr_bits-1:0] awaddr_m1,
	input  logic [axi_pkg::len_bits-1:0]  awlen_m0,
	input  logic [axi_pkg::len_bits-1:0]  awlen_m1,
	input  logic                          awvalid_m0,
	input  logic                          awvalid_m1,
	output logic                          awready_m0,
	output logic                          awready_m1,
	output logic [axi_pkg::ids_bits-1:0]  awid_s0, awid_s1, awid_s2,
	output logic [axi_pkg::addr_bits-1:0] awaddr_s0, awaddr_s1, awaddr_s2,
	output logic [axi_pkg::len_bits-1:0]  awlen_s0, awlen_s1, awlen_s2,
	output logic                          awvalid_s0, awvalid_s1, awvalid_s2,
	input  logic                          awready_s0, awready_s1, awready_s2,
	output logic                          aw_done
);

	// Master index as tag
	localparam logic [axi_pkg::tag_bits-1:0] tag_m0 = '0;
	localparam logic [axi_pkg::tag_bits-1:0] tag_m1 = {{(axi_pkg::tag_bits-1){1'b0}}, 1'b1};

	// Granted request, already widened
	axi_pkg::slave_id_u            id_bus;
	logic [axi_pkg::addr_bits-1:0] addr_bus;
	logic [axi_pkg::len_bits-1:0]  len_bus;
	logic                          valid_bus;
	logic                          ready_bus;

	// Master onto bus by ADDR state
	always_comb begin
		id_bus     = '0;
		addr_bus   = '0;
		len_bus    = '0;
		valid_bus  = 1'b0;
		awready_m0 = 1'b0;
		awready_m1 = 1'b0;
		case (cs)
			axi_pkg::w_m0_addr: begin
				id_bus.fld.tag = tag_m0;
				id_bus.fld.mid = awid_m0;
				addr_bus       = awaddr_m0;
				len_bus        = awlen_m0;
				valid_bus      = awvalid_m0;
				awready_m0     = ready_bus;
			end
			axi_pkg::w_m1_addr: begin
				id_bus.fld.tag = tag_m1;
				id_bus.fld.mid = awid_m1;
				addr_bus       = awaddr_m1;
				len_bus        = awlen_m1;
				valid_bus      = awvalid_m1;
				awready_m1     = ready_bus;
			end
			default: begin
			end
		endcase
	end

	// Bus out to the decoded slave
	always_comb begin
		{awid_s0, awaddr_s0, awlen_s0, awvalid_s0} = '0;
		{awid_s1, awaddr_s1, awlen_s1, awvalid_s1} = '0;
		{awid_s2, awaddr_s2, awlen_s2, awvalid_s2} = '0;
		case (slave)
			axi_pkg::sel_s0: begin
				{awid_s0, awaddr_s0, awlen_s0, awvalid_s0} = {id_bus.raw, addr_bus, len_bus, valid_bus};
				ready_bus = awready_s0;
			end
			axi_pkg::sel_s1: begin
				{awid_s1, awaddr_s1, awlen_s1, awvalid_s1} = {id_bus.raw, addr_bus, len_bus, valid_bus};
				ready_bus = awready_s1;
			end
			axi_pkg::sel_s2: begin
				{awid_s2, awaddr_s2, awlen_s2, awvalid_s2} = {id_bus.raw, addr_bus, len_bus, valid_bus};
				ready_bus = awready_s2;
			end
			// No slave, accept here and answer DECERR later
			default: begin
				ready_bus = 1'b1;
			end
		endcase
	end

	assign aw_done = valid_bus && ready_bus;

endmodule

// ==== hdl/axi_pkg.sv ====
package axi_pkg;

	// Bus widths
	localparam int addr_bits = 32;
	localparam int id_bits   = 4;
	// Slave side ID carries the master tag above the master ID
	localparam int ids_bits  = 8;
	localparam int tag_bits  = ids_bits - id_bits;
	localparam int data_bits = 32;
	localparam int strb_bits = data_bits / 8;
	localparam int len_bits  = 4;

	// Write response codes, EXOKAY never produced
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} resp_t;

	// Write sequencing, one transaction in flight
	typedef enum logic [3:0] {
		w_idle    = 4'd0,
		w_m0_addr = 4'd1,
		w_m1_addr = 4'd2,
		w_m0_data = 4'd3,
		w_m1_data = 4'd4,
		w_m0_b    = 4'd5,
		w_m1_b    = 4'd6
	} wstate_t;

	// Decoded from address bits 17:16
	typedef enum logic [1:0] {
		sel_s0   = 2'd0,
		sel_s1   = 2'd1,
		sel_s2   = 2'd2,
		sel_none = 2'd3
	} slave_sel_t;

	// Slave side ID, raw word or tag plus master ID
	typedef union packed {
		logic [ids_bits-1:0] raw;
		struct packed {
			logic [tag_bits-1:0] tag;
			logic [id_bits-1:0]  mid;
		} fld;
	} slave_id_u;

endpackage

// ==== hdl/axi_write_crossbar.sv ====
`timescale 1ns/1ps

module axi_write_crossbar #(
	parameter int timeout_cycles = 16
) (
	input  logic                          aclk,
	input  logic                          rst_n,
	// Master AW
	input  logic [axi_pkg::id_bits-1:0]   awid_m0, awid_m1,
	input  logic [axi_pkg::addr_bits-1:0] awaddr_m0, awaddr_m1,
	input  logic [axi_pkg::len_bits-1:0]  awlen_m0, awlen_m1,
	input  logic                          awvalid_m0, awvalid_m1,
	output logic                          awready_m0, awready_m1,
	// Master W
	input  logic [axi_pkg::data_bits-1:0] wdata_m0, wdata_m1,
	input  logic [axi_pkg::strb_bits-1:0] wstrb_m0, wstrb_m1,
	input  logic                          wlast_m0, wlast_m1,
	input  logic                          wvalid_m0, wvalid_m1,
	output logic                          wready_m0, wready_m1,
	// Master B
	output logic [axi_pkg::id_bits-1:0]   bid_m0, bid_m1,
	output logic [1:0]                    bresp_m0, bresp_m1,
	output logic                          bvalid_m0, bvalid_m1,
	input  logic                          bready_m0, bready_m1,
	// Slave AW, widened IDs
	output logic [axi_pkg::ids_bits-1:0]  awid_s0, awid_s1, awid_s2,
	output logic [axi_pkg::addr_bits-1:0] awaddr_s0, awaddr_s1, awaddr_s2,
	output logic [axi_pkg::len_bits-1:0]  awlen_s0, awlen_s1, awlen_s2,
	output logic                          awvalid_s0, awvalid_s1, awvalid_s2,
	input  logic                          awready_s0, awready_s1, awready_s2,
	// Slave W
	output logic [axi_pkg::data_bits-1:0] wdata_s0, wdata_s1, wdata_s2,
	output logic [axi_pkg::strb_bits-1:0] wstrb_s0, wstrb_s1, wstrb_s2,
	output logic                          wlast_s0, wlast_s1, wlast_s2,
	output logic                          wvalid_s0, wvalid_s1, wvalid_s2,
	input  logic                          wready_s0, wready_s1, wready_s2,
	// Slave B
	input  logic [axi_pkg::ids_bits-1:0]  bid_s0, bid_s1, bid_s2,
	input  logic [1:0]                    bresp_s0, bresp_s1, bresp_s2,
	input  logic                          bvalid_s0, bvalid_s1, bvalid_s2,
	output logic                          bready_s0, bready_s1, bready_s2
);

	// Steering from the FSM
	axi_pkg::wstate_t    cs;
	axi_pkg::slave_sel_t slave;
	// Phase handshakes back to the FSM
	logic                aw_done;
	logic                w_done;
	logic                b_done;
	// B-phase watchdog
	logic                slave_bvalid;
	logic                timeout;

	write_arbiter_fsm u_fsm (.*);

	response_timer #(
		.timeout_cycles(timeout_cycles)
	) u_timer (.*);

	aw_channel u_aw (.*);

	w_channel u_w (.*);

	b_channel u_b (.*);

endmodule

// ==== hdl/b_channel.sv ====
`timescale 1ns/1ps

module b_channel (
	input  logic                          aclk,
	input  axi_pkg::wstate_t              cs,
	input  axi_pkg::slave_sel_t           slave,
	input  logic                          timeout,
	input  logic                          aw_done,
	input  logic [axi_pkg::id_bits-1:0]   awid_m0,
	input  logic [axi_pkg::id_bits-1:0]   awid_m1,
	input  logic [axi_pkg::ids_bits-1:0]  bid_s0, bid_s1, bid_s2,
	input  logic [1:0]                    bresp_s0, bresp_s1, bresp_s2,
	input  logic                          bvalid_s0, bvalid_s1, bvalid_s2,
	output logic                          bready_s0, bready_s1, bready_s2,
	output logic [axi_pkg::id_bits-1:0]   bid_m0, bid_m1,
	output logic [1:0]                    bresp_m0, bresp_m1,
	output logic                          bvalid_m0, bvalid_m1,
	input  logic                          bready_m0, bready_m1,
	output logic                          slave_bvalid,
	output logic                          b_done
);

	// Selected slave's response
	axi_pkg::slave_id_u          bid_bus;
	logic [1:0]                  bresp_bus;
	logic                        bvalid_bus;
	// Response toward the master, passed through or generated
	logic [axi_pkg::id_bits-1:0] rsp_id;
	logic [1:0]                  rsp_code;
	logic                        rsp_valid;
	logic                        rsp_ready;
	// ID of the write in flight
	logic [axi_pkg::id_bits-1:0] err_id;

	// Captured at AW for generated responses
	always_ff @(posedge aclk) begin
		if (aw_done) begin
			err_id <= (cs == axi_pkg::w_m1_addr) ? awid_m1 : awid_m0;
		end
	end

	// Stage one, slave onto bus
	always_comb begin
		bid_bus   = '0;
		bresp_bus = '0;
		bvalid_bus = 1'b0;
		bready_s0 = 1'b0;
		bready_s1 = 1'b0;
		bready_s2 = 1'b0;
		// After timeout the late answer is swallowed
		case (slave)
			axi_pkg::sel_s0: begin
				{bid_bus, bresp_bus, bvalid_bus} = {bid_s0, bresp_s0, bvalid_s0};
				bready_s0 = rsp_ready || timeout;
			end
			axi_pkg::sel_s1: begin
				{bid_bus, bresp_bus, bvalid_bus} = {bid_s1, bresp_s1, bvalid_s1};
				bready_s1 = rsp_ready || timeout;
			end
			axi_pkg::sel_s2: begin
				{bid_bus, bresp_bus, bvalid_bus} = {bid_s2, bresp_s2, bvalid_s2};
				bready_s2 = rsp_ready || timeout;
			end
			default: begin
			end
		endcase
	end

	assign slave_bvalid = bvalid_bus;

	// Decode error first, then timeout, else the slave
	always_comb begin
		if (slave == axi_pkg::sel_none) begin
			rsp_id    = err_id;
			rsp_code  = axi_pkg::resp_decerr;
			rsp_valid = 1'b1;
		end else if (timeout) begin
			rsp_id    = err_id;
			rsp_code  = axi_pkg::resp_slverr;
			rsp_valid = 1'b1;
		end else begin
			// Tag stripped, master ID only
			rsp_id    = bid_bus.fld.mid;
			rsp_code  = bresp_bus;
			rsp_valid = bvalid_bus;
		end
	end

	// Stage two, bus to the master named by the B state
	always_comb begin
		{bid_m0, bresp_m0, bvalid_m0} = '0;
		{bid_m1, bresp_m1, bvalid_m1} = '0;
		rsp_ready = 1'b0;
		case (cs)
			axi_pkg::w_m0_b: begin
				{bid_m0, bresp_m0, bvalid_m0} = {rsp_id, rsp_code, rsp_valid};
				rsp_ready = bready_m0;
			end
			axi_pkg::w_m1_b: begin
				{bid_m1, bresp_m1, bvalid_m1} = {rsp_id, rsp_code, rsp_valid};
				rsp_ready = bready_m1;
			end
			default: begin
			end
		endcase
	end

	assign b_done = rsp_valid && rsp_ready;

endmodule

// ==== hdl/response_timer.sv ====
`timescale 1ns/1ps

module response_timer #(
	parameter int timeout_cycles = 16
) (
	input  logic             aclk,
	input  logic             rst_n,
	input  axi_pkg::wstate_t cs,
	input  logic             slave_bvalid,
	output logic             timeout
);

	localparam int                  cnt_bits = $clog2(timeout_cycles + 1);
	localparam logic [cnt_bits-1:0] limit    = cnt_bits'(timeout_cycles);

	logic                in_b;
	logic [cnt_bits-1:0] count;

	assign in_b = (cs == axi_pkg::w_m0_b) || (cs == axi_pkg::w_m1_b);

	// Cleared outside B, saturates at the limit
	always_ff @(posedge aclk) begin
		if (!rst_n || !in_b) begin
			count <= '0;
		end else if (!slave_bvalid && (count != limit)) begin
			// Only slave silence counts, master back-pressure does not
			count <= count + 1'b1;
		end
	end

	// Held until the state leaves B
	assign timeout = in_b && (count == limit);

endmodule

// ==== hdl/w_channel.sv ====
`timescale 1ns/1ps

module w_channel (
	input  axi_pkg::wstate_t              cs,
	input  axi_pkg::slave_sel_t           slave,
	input  logic [axi_pkg::data_bits-1:0] wdata_m0,
	input  logic [axi_pkg::data_bits-1:0] wdata_m1,
	input  logic [axi_pkg::strb_bits-1:0] wstrb_m0,
	input  logic [axi_pkg::strb_bits-1:0] wstrb_m1,
	input  logic                          wlast_m0,
	input  logic                          wlast_m1,
	input  logic                          wvalid_m0,
	input  logic                          wvalid_m1,
	output logic                          wready_m0,
	output logic                          wready_m1,
	output logic [axi_pkg::data_bits-1:0] wdata_s0, wdata_s1, wdata_s2,
	output logic [axi_pkg::strb_bits-1:0] wstrb_s0, wstrb_s1, wstrb_s2,
	output logic                          wlast_s0, wlast_s1, wlast_s2,
	output logic                          wvalid_s0, wvalid_s1, wvalid_s2,
	input  logic                          wready_s0, wready_s1, wready_s2,
	output logic                          w_done
);

	// Beat from the granted master
	logic [axi_pkg::data_bits-1:0] data_bus;
	logic [axi_pkg::strb_bits-1:0] strb_bus;
	logic                          last_bus;
	logic                          valid_bus;
	logic                          ready_bus;

	// Master onto bus by DATA state
	always_comb begin
		data_bus  = '0;
		strb_bus  = '0;
		last_bus  = 1'b0;
		valid_bus = 1'b0;
		wready_m0 = 1'b0;
		wready_m1 = 1'b0;
		case (cs)
			axi_pkg::w_m0_data: begin
				{data_bus, strb_bus, last_bus, valid_bus} = {wdata_m0, wstrb_m0, wlast_m0, wvalid_m0};
				wready_m0 = ready_bus;
			end
			axi_pkg::w_m1_data: begin
				{data_bus, strb_bus, last_bus, valid_bus} = {wdata_m1, wstrb_m1, wlast_m1, wvalid_m1};
				wready_m1 = ready_bus;
			end
			default: begin
			end
		endcase
	end

	// Bus out to the decoded slave
	always_comb begin
		{wdata_s0, wstrb_s0, wlast_s0, wvalid_s0} = '0;
		{wdata_s1, wstrb_s1, wlast_s1, wvalid_s1} = '0;
		{wdata_s2, wstrb_s2, wlast_s2, wvalid_s2} = '0;
		case (slave)
			axi_pkg::sel_s0: begin
				{wdata_s0, wstrb_s0, wlast_s0, wvalid_s0} = {data_bus, strb_bus, last_bus, valid_bus};
				ready_bus = wready_s0;
			end
			axi_pkg::sel_s1: begin
				{wdata_s1, wstrb_s1, wlast_s1, wvalid_s1} = {data_bus, strb_bus, last_bus, valid_bus};
				ready_bus = wready_s1;
			end
			axi_pkg::sel_s2: begin
				{wdata_s2, wstrb_s2, wlast_s2, wvalid_s2} = {data_bus, strb_bus, last_bus, valid_bus};
				ready_bus = wready_s2;
			end
			// Sink beats bound for no slave
			default: begin
				ready_bus = 1'b1;
			end
		endcase
	end

	// Only the accepted last beat closes the phase
	assign w_done = valid_bus && ready_bus && last_bus;

endmodule

// ==== hdl/write_arbiter_fsm.sv ====
`timescale 1ns/1ps

module write_arbiter_fsm (
	input  logic                          aclk,
	input  logic                          rst_n,
	input  logic                          awvalid_m0,
	input  logic                          awvalid_m1,
	input  logic [axi_pkg::addr_bits-1:0] awaddr_m0,
	input  logic [axi_pkg::addr_bits-1:0] awaddr_m1,
	input  logic                          aw_done,
	input  logic                          w_done,
	input  logic                          b_done,
	output axi_pkg::wstate_t              cs,
	output axi_pkg::slave_sel_t           slave
);

	// High when M1 held the last grant
	logic last_m1;
	logic pick_m0;

	// M0 wins alone, or on a tie once M1 had its turn
	assign pick_m0 = awvalid_m0 && (!awvalid_m1 || last_m1);

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			cs      <= axi_pkg::w_idle;
			slave   <= axi_pkg::sel_none;
			// M0 goes first after reset
			last_m1 <= 1'b1;
		end else begin
			case (cs)
				axi_pkg::w_idle: begin
					// Grant and latch the target slave together
					if (pick_m0) begin
						cs      <= axi_pkg::w_m0_addr;
						slave   <= axi_pkg::slave_sel_t'(awaddr_m0[17:16]);
						last_m1 <= 1'b0;
					end else if (awvalid_m1) begin
						cs      <= axi_pkg::w_m1_addr;
						slave   <= axi_pkg::slave_sel_t'(awaddr_m1[17:16]);
						last_m1 <= 1'b1;
					end
				end
				// Address phase ends on the AW handshake
				axi_pkg::w_m0_addr: begin
					if (aw_done) begin
						cs <= axi_pkg::w_m0_data;
					end
				end
				axi_pkg::w_m1_addr: begin
					if (aw_done) begin
						cs <= axi_pkg::w_m1_data;
					end
				end
				// Data phase ends on the accepted last beat
				axi_pkg::w_m0_data: begin
					if (w_done) begin
						cs <= axi_pkg::w_m0_b;
					end
				end
				axi_pkg::w_m1_data: begin
					if (w_done) begin
						cs <= axi_pkg::w_m1_b;
					end
				end
				// Response taken by the master
				axi_pkg::w_m0_b, axi_pkg::w_m1_b: begin
					if (b_done) begin
						cs <= axi_pkg::w_idle;
					end
				end
				default: begin
					cs <= axi_pkg::w_idle;
				end
			endcase
		end
	end

endmodule

// ==== project.f ====
hdl/axi_pkg.sv
hdl/write_arbiter_fsm.sv
hdl/response_timer.sv
hdl/aw_channel.sv
hdl/w_channel.sv
hdl/b_channel.sv
hdl/axi_write_crossbar.sv
testbench/tb_axi_write_crossbar.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the write crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f project.f --top-module tb_axi_write_crossbar -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1

// ==== testbench/tb_axi_write_crossbar.sv ====
`timescale 1ns/1ps

module tb_axi_write_crossbar;

	localparam int timeout_cycles = 16;
	localparam int n_rows         = 19;
	// Worst row is a timed out write or a 16 beat burst
	localparam int row_budget     = timeout_cycles + 40;

	localparam logic [1:0] okay   = axi_pkg::resp_okay;
	localparam logic [1:0] slverr = axi_pkg::resp_slverr;
	localparam logic [1:0] decerr = axi_pkg::resp_decerr;

	// One write, pair marks a row issued together with the next one
	typedef struct packed {
		logic        m;
		logic        pair;
		logic [31:0] addr;
		logic [3:0]  len;
		logic [7:0]  delay;
		logic [7:0]  hold;
		logic [1:0]  code;
		logic [1:0]  exp_resp;
		logic [1:0]  exp_slave;
	} row_t;

	// Master, pair, address, awlen, slave delay, bready hold, slave code, bresp, slave
	localparam row_t rows [n_rows] = '{
		'{1'b0, 1'b0, 32'h0000_1000, 4'd0, 8'd0, 8'd0, okay, okay, 2'd0},
		'{1'b1, 1'b0, 32'h0000_2004, 4'd0, 8'd1, 8'd0, okay, okay, 2'd0},
		'{1'b0, 1'b0, 32'h0001_0040, 4'd0, 8'd0, 8'd0, okay, okay, 2'd1},
		'{1'b1, 1'b0, 32'h0001_8000, 4'd0, 8'd2, 8'd0, slverr, slverr, 2'd1},
		'{1'b0, 1'b0, 32'h0002_0100, 4'd0, 8'd0, 8'd0, okay, okay, 2'd2},
		'{1'b1, 1'b0, 32'h0002_0200, 4'd0, 8'd4, 8'd0, okay, okay, 2'd2},
		// Bursts
		'{1'b0, 1'b0, 32'h0001_0400, 4'd7, 8'd0, 8'd0, okay, okay, 2'd1},
		'{1'b1, 1'b0, 32'h0002_0800, 4'd15, 8'd3, 8'd0, okay, okay, 2'd2},
		// Unmapped, bits 17:16 equal 3
		'{1'b0, 1'b0, 32'h0003_0000, 4'd3, 8'd0, 8'd0, okay, decerr, 2'd3},
		'{1'b1, 1'b0, 32'h0003_1000, 4'd0, 8'd0, 8'd0, okay, decerr, 2'd3},
		// Silent slaves
		'{1'b0, 1'b0, 32'h0000_3000, 4'd0, 8'd255, 8'd0, okay, slverr, 2'd0},
		'{1'b1, 1'b0, 32'h0002_3000, 4'd2, 8'd255, 8'd0, okay, slverr, 2'd2},
		// Slow slave, then a master that stalls B
		'{1'b0, 1'b0, 32'h0001_5000, 4'd0, 8'd10, 8'd0, okay, okay, 2'd1},
		'{1'b1, 1'b0, 32'h0000_6000, 4'd0, 8'd2, 8'd30, okay, okay, 2'd0},
		// Both masters at once
		'{1'b0, 1'b1, 32'h0000_7000, 4'd1, 8'd0, 8'd0, okay, okay, 2'd0},
		'{1'b1, 1'b0, 32'h0002_7000, 4'd2, 8'd1, 8'd0, okay, okay, 2'd2},
		'{1'b0, 1'b0, 32'h0002_9000, 4'd0, 8'd0, 8'd0, okay, okay, 2'd2},
		'{1'b0, 1'b1, 32'h0001_a000, 4'd0, 8'd0, 8'd0, okay, okay, 2'd1},
		'{1'b1, 1'b0, 32'h0000_b000, 4'd0, 8'd255, 8'd0, okay, slverr, 2'd0}
	};

	logic aclk = 1'b0;
	logic rst_n;

	// Master side, index is the master
	logic [3:0]  awid_m [2];
	logic [31:0] awaddr_m [2];
	logic [3:0]  awlen_m [2];
	logic        awvalid_m [2];
	logic        awready_m [2];
	logic [31:0] wdata_m [2];
	logic [3:0]  wstrb_m [2];
	logic        wlast_m [2];
	logic        wvalid_m [2];
	logic        wready_m [2];
	logic [3:0]  bid_m [2];
	logic [1:0]  bresp_m [2];
	logic        bvalid_m [2];
	logic        bready_m [2];
	// Slave side, index is the slave
	logic [7:0]  awid_s [3];
	logic [31:0] awaddr_s [3];
	logic [3:0]  awlen_s [3];
	logic        awvalid_s [3];
	logic        awready_s [3];
	logic [31:0] wdata_s [3];
	logic [3:0]  wstrb_s [3];
	logic        wlast_s [3];
	logic        wvalid_s [3];
	logic        wready_s [3];
	logic [7:0]  bid_s [3];
	logic [1:0]  bresp_s [3];
	logic        bvalid_s [3];
	logic        bready_s [3];

	// Slave model state
	logic [7:0]  rx_id [3];
	logic [31:0] rx_addr [3];
	logic [3:0]  rx_len [3];
	int          beat_idx [3];
	logic        armed [3];
	int          wait_cnt [3];
	int          aw_seen [3];
	int          beats_seen [3];
	logic [31:0] wsum [3];
	int          sl_delay [3];
	logic [1:0]  sl_code [3];

	// Per group bookkeeping
	logic [3:0]  txn_id [2];
	logic [31:0] txn_data [2][16];
	int          aw_order [2];
	int          base_aw [3];
	int          base_beats [3];
	logic [31:0] base_sum [3];
	int          exp_aw [3];
	int          exp_beats [3];
	logic [31:0] exp_sum [3];
	int          order_seq;
	int          last_served;
	int          errors;
	int          n_checks;
	int          seed;
	int          row;
	int          cnt;
	int          first;
	int          k;
	int          b;
	int          s;

	always #20 aclk = ~aclk;

	axi_write_crossbar #(
		.timeout_cycles(timeout_cycles)
	) DUT (
		.aclk(aclk),
		.rst_n(rst_n),
		.awid_m0(awid_m[0]), .awid_m1(awid_m[1]),
		.awaddr_m0(awaddr_m[0]), .awaddr_m1(awaddr_m[1]),
		.awlen_m0(awlen_m[0]), .awlen_m1(awlen_m[1]),
		.awvalid_m0(awvalid_m[0]), .awvalid_m1(awvalid_m[1]),
		.awready_m0(awready_m[0]), .awready_m1(awready_m[1]),
		.wdata_m0(wdata_m[0]), .wdata_m1(wdata_m[1]),
		.wstrb_m0(wstrb_m[0]), .wstrb_m1(wstrb_m[1]),
		.wlast_m0(wlast_m[0]), .wlast_m1(wlast_m[1]),
		.wvalid_m0(wvalid_m[0]), .wvalid_m1(wvalid_m[1]),
		.wready_m0(wready_m[0]), .wready_m1(wready_m[1]),
		.bid_m0(bid_m[0]), .bid_m1(bid_m[1]),
		.bresp_m0(bresp_m[0]), .bresp_m1(bresp_m[1]),
		.bvalid_m0(bvalid_m[0]), .bvalid_m1(bvalid_m[1]),
		.bready_m0(bready_m[0]), .bready_m1(bready_m[1]),
		.awid_s0(awid_s[0]), .awid_s1(awid_s[1]), .awid_s2(awid_s[2]),
		.awaddr_s0(awaddr_s[0]), .awaddr_s1(awaddr_s[1]), .awaddr_s2(awaddr_s[2]),
		.awlen_s0(awlen_s[0]), .awlen_s1(awlen_s[1]), .awlen_s2(awlen_s[2]),
		.awvalid_s0(awvalid_s[0]), .awvalid_s1(awvalid_s[1]), .awvalid_s2(awvalid_s[2]),
		.awready_s0(awready_s[0]), .awready_s1(awready_s[1]), .awready_s2(awready_s[2]),
		.wdata_s0(wdata_s[0]), .wdata_s1(wdata_s[1]), .wdata_s2(wdata_s[2]),
		.wstrb_s0(wstrb_s[0]), .wstrb_s1(wstrb_s[1]), .wstrb_s2(wstrb_s[2]),
		.wlast_s0(wlast_s[0]), .wlast_s1(wlast_s[1]), .wlast_s2(wlast_s[2]),
		.wvalid_s0(wvalid_s[0]), .wvalid_s1(wvalid_s[1]), .wvalid_s2(wvalid_s[2]),
		.wready_s0(wready_s[0]), .wready_s1(wready_s[1]), .wready_s2(wready_s[2]),
		.bid_s0(bid_s[0]), .bid_s1(bid_s[1]), .bid_s2(bid_s[2]),
		.bresp_s0(bresp_s[0]), .bresp_s1(bresp_s[1]), .bresp_s2(bresp_s[2]),
		.bvalid_s0(bvalid_s[0]), .bvalid_s1(bvalid_s[1]), .bvalid_s2(bvalid_s[2]),
		.bready_s0(bready_s[0]), .bready_s1(bready_s[1]), .bready_s2(bready_s[2])
	);

	task check(input string what, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// Three slaves, always ready, answer B after the configured delay
	task slave_step();
		int i;
		for (i = 0; i < 3; i++) begin
			if (!rst_n) begin
				awready_s[i]  <= 1'b0;
				wready_s[i]   <= 1'b0;
				bvalid_s[i]   <= 1'b0;
				armed[i]      <= 1'b0;
				aw_seen[i]    <= 0;
				beats_seen[i] <= 0;
				beat_idx[i]   <= 0;
				wsum[i]       <= '0;
			end else begin
				awready_s[i] <= 1'b1;
				wready_s[i]  <= 1'b1;
				if (awvalid_s[i] && awready_s[i]) begin
					rx_id[i]    <= awid_s[i];
					rx_addr[i]  <= awaddr_s[i];
					rx_len[i]   <= awlen_s[i];
					beat_idx[i] <= 0;
					aw_seen[i]  <= aw_seen[i] + 1;
				end
				if (wvalid_s[i] && wready_s[i]) begin
					// wlast only on the beat that awlen names
					check("wlast at slave", 32'(wlast_s[i]),
						32'(beat_idx[i] == int'(rx_len[i])));
					beat_idx[i]   <= beat_idx[i] + 1;
					beats_seen[i] <= beats_seen[i] + 1;
					wsum[i]       <= wsum[i] + wdata_s[i] + 32'(wstrb_s[i]);
					// Delay of 255 never answers
					if (wlast_s[i]) begin
						armed[i]    <= (sl_delay[i] != 255);
						wait_cnt[i] <= sl_delay[i];
					end
				end
				if (armed[i]) begin
					if (wait_cnt[i] == 0) begin
						bvalid_s[i] <= 1'b1;
						bresp_s[i]  <= sl_code[i];
						bid_s[i]    <= rx_id[i];
						armed[i]    <= 1'b0;
					end else begin
						wait_cnt[i] <= wait_cnt[i] - 1;
					end
				end
				if (bvalid_s[i] && bready_s[i]) begin
					bvalid_s[i] <= 1'b0;
				end
			end
		end
	endtask

	// One full write from a master, checked at the B handshake
	task automatic drive_write(input int r, input int slot);
		int m;
		int sl;
		int beat;
		m  = int'(rows[r].m);
		sl = int'(rows[r].exp_slave);
		@(posedge aclk);
		awid_m[m]    <= txn_id[slot];
		awaddr_m[m]  <= rows[r].addr;
		awlen_m[m]   <= rows[r].len;
		awvalid_m[m] <= 1'b1;
		@(posedge aclk);
		while (!awready_m[m]) begin
			@(posedge aclk);
		end
		awvalid_m[m]   <= 1'b0;
		aw_order[slot] = order_seq;
		order_seq++;
		// First beat goes out on the AW edge
		for (beat = 0; beat <= int'(rows[r].len); beat++) begin
			wdata_m[m]  <= txn_data[slot][beat];
			// Strobe taken from the low data nibble
			wstrb_m[m]  <= txn_data[slot][beat][3:0];
			wlast_m[m]  <= (beat == int'(rows[r].len));
			wvalid_m[m] <= 1'b1;
			@(posedge aclk);
			while (!wready_m[m]) begin
				@(posedge aclk);
			end
			check("bvalid before last beat accepted", 32'(bvalid_m[m]), 32'd0);
		end
		wvalid_m[m] <= 1'b0;
		wlast_m[m]  <= 1'b0;
		bready_m[m] <= (rows[r].hold == 8'd0);
		@(posedge aclk);
		while (!bvalid_m[m]) begin
			check("other master bvalid while waiting", 32'(bvalid_m[1 - m]), 32'd0);
			@(posedge aclk);
		end
		// Stalled master, response must wait
		if (rows[r].hold != 8'd0) begin
			repeat (int'(rows[r].hold)) @(posedge aclk);
			bready_m[m] <= 1'b1;
			@(posedge aclk);
			check("bvalid held to handshake", 32'(bvalid_m[m]), 32'd1);
		end
		check("other master bvalid", 32'(bvalid_m[1 - m]), 32'd0);
		check("bresp", 32'(bresp_m[m]), 32'(rows[r].exp_resp));
		check("bid", 32'(bid_m[m]), 32'(txn_id[slot]));
		if (sl != 3) begin
			check("slave side awid", 32'(rx_id[sl]), 32'({3'b000, rows[r].m, txn_id[slot]}));
			check("slave side awaddr", rx_addr[sl], rows[r].addr);
			check("slave side awlen", 32'(rx_len[sl]), 32'(rows[r].len));
			check("slave side bready", 32'(bready_s[sl]), 32'd1);
		end
		bready_m[m] <= 1'b0;
	endtask

	initial begin
		seed        = 32'h7ceb009e;
		errors      = 0;
		n_checks    = 0;
		order_seq   = 0;
		last_served = -1;
		rst_n       = 1'b0;
		for (k = 0; k < 2; k++) begin
			awid_m[k]    = '0;
			awaddr_m[k]  = '0;
			awlen_m[k]   = '0;
			awvalid_m[k] = 1'b0;
			wdata_m[k]   = '0;
			wstrb_m[k]   = '0;
			wlast_m[k]   = 1'b0;
			wvalid_m[k]  = 1'b0;
			bready_m[k]  = 1'b0;
		end
		for (s = 0; s < 3; s++) begin
			awready_s[s] = 1'b0;
			wready_s[s]  = 1'b0;
			bid_s[s]     = '0;
			bresp_s[s]   = '0;
			bvalid_s[s]  = 1'b0;
			sl_delay[s]  = 0;
			sl_code[s]   = okay;
		end
		fork
			forever begin
				@(posedge aclk);
				slave_step();
			end
		join_none
		repeat (16) @(posedge aclk);
		rst_n <= 1'b1;
		row = 0;
		while (row < n_rows) begin
			cnt = rows[row].pair ? 2 : 1;
			for (s = 0; s < 3; s++) begin
				base_aw[s]    = aw_seen[s];
				base_beats[s] = beats_seen[s];
				base_sum[s]   = wsum[s];
				exp_aw[s]     = 0;
				exp_beats[s]  = 0;
				exp_sum[s]    = '0;
			end
			// Expected slave traffic comes from the decoded address
			for (k = 0; k < cnt; k++) begin
				txn_id[k] = 4'($random(seed));
				s = int'(rows[row + k].exp_slave);
				for (b = 0; b <= int'(rows[row + k].len); b++) begin
					txn_data[k][b] = $random(seed);
					if (s != 3) begin
						exp_sum[s] = exp_sum[s] + txn_data[k][b] + 32'(txn_data[k][b][3:0]);
					end
				end
				if (s != 3) begin
					exp_aw[s]    = exp_aw[s] + 1;
					exp_beats[s] = exp_beats[s] + int'(rows[row + k].len) + 1;
					sl_delay[s]  = int'(rows[row + k].delay);
					sl_code[s]   = rows[row + k].code;
				end
			end
			if (cnt == 2) begin
				fork
					drive_write(row, 0);
					drive_write(row + 1, 1);
				join
			end else begin
				drive_write(row, 0);
			end
			for (s = 0; s < 3; s++) begin
				check("AW transfers at slave", 32'(aw_seen[s] - base_aw[s]), 32'(exp_aw[s]));
				check("W beats at slave", 32'(beats_seen[s] - base_beats[s]), 32'(exp_beats[s]));
				check("W data and strobe sum at slave", wsum[s] - base_sum[s], exp_sum[s]);
			end
			// Tie goes to the master not served last
			if (cnt == 2) begin
				first = int'(rows[row + ((aw_order[0] < aw_order[1]) ? 0 : 1)].m);
				if (last_served >= 0) begin
					check("grant order on tie", 32'(first), 32'(1 - last_served));
				end
				last_served = 1 - first;
			end else begin
				last_served = int'(rows[row].m);
			end
			row = row + cnt;
		end
		$display("Checks: %0d, errors: %0d", n_checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Hang guard
	initial begin
		repeat (16 + n_rows * row_budget) @(posedge aclk);
		$display("Watchdog expired before all writes completed, the DUT appears hung");
		$display("Checks: %0d, errors: %0d", n_checks, errors);
		$display("=== FAIL ===");
		$finish;
	end

endmodule
